/* evict_pkg.sv */
package evict_pkg;

    // buffer geometry
    localparam int GROUP_NUM       = 8;
    localparam int GROUP_IDX_W     = $clog2(GROUP_NUM);
    localparam int BEATS_PER_GROUP = 4;
    localparam int BEAT_IDX_W      = 2;
    localparam int ENTRY_IDX_W     = GROUP_IDX_W + BEAT_IDX_W; // {group, beat}
    localparam int DATA_WIDTH      = 64;

    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 6;
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;

    localparam int ROB_IDX_W  = 4;
    localparam int TXNID_W    = 8;
    localparam int SIDEBAND_W = 4;

    localparam int DEF_READ_SRAM_DELAY = 3;
    localparam int DEF_QUEUE_DEPTH     = 32;

    typedef struct packed {
        logic [ENTRY_IDX_W-1:0] db_entry_id;
        logic [ROB_IDX_W-1:0]   rob_entry_id;
        logic [TXNID_W-1:0]     txnid;
        logic [SIDEBAND_W-1:0]  sideband;
        logic [TAG_W-1:0]       tag;
        logic [INDEX_W-1:0]     index;
        logic [OFFSET_W-1:0]    offset;
        logic                   last;    // beat 3 of the group
    } evict_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]  data;
        logic [ENTRY_IDX_W-1:0] db_entry_id;
        logic [ROB_IDX_W-1:0]   rob_entry_id;
        logic [TXNID_W-1:0]     txnid;
        logic [SIDEBAND_W-1:0]  sideband;
        logic [ADDR_W-1:0]      addr;    // {tag, index, offset}
        logic                   last;
    } evict_out_t;

endpackage

/* evict_tap_if.sv */
`timescale 1ns/1ps

interface evict_tap_if;

    logic                            wr_vld;    // delayed transfer strobe
    evict_pkg::evict_req_t           wr_pld;
    logic                            clean;     // last beat being written
    logic [evict_pkg::ROB_IDX_W-1:0] clean_rob;

    modport src (
        output wr_vld,
        output wr_pld,
        output clean,
        output clean_rob
    );

    modport dst (
        input  wr_vld,
        input  wr_pld,
        input  clean,
        input  clean_rob
    );

endinterface

/* evict_delay_line.sv */
`timescale 1ns/1ps

module evict_delay_line #(
    parameter int READ_SRAM_DELAY = evict_pkg::DEF_READ_SRAM_DELAY
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_fire,
    input  evict_pkg::evict_req_t req_pld,
    evict_tap_if.src              tap
);

    logic [READ_SRAM_DELAY-1:0] vld_sr;
    evict_pkg::evict_req_t      pld_sr [READ_SRAM_DELAY];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= req_fire;
            for (int i = 1; i < READ_SRAM_DELAY; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    // payload chain follows the strobe
    always_ff @(posedge clk) begin
        pld_sr[0] <= req_pld;
        for (int i = 1; i < READ_SRAM_DELAY; i++) begin
            pld_sr[i] <= pld_sr[i-1];
        end
    end

    // last stage lines up with the sram data return
    assign tap.wr_vld    = vld_sr[READ_SRAM_DELAY-1];
    assign tap.wr_pld    = pld_sr[READ_SRAM_DELAY-1];
    assign tap.clean     = vld_sr[READ_SRAM_DELAY-1] & pld_sr[READ_SRAM_DELAY-1].last;
    assign tap.clean_rob = pld_sr[READ_SRAM_DELAY-1].rob_entry_id;

endmodule

/* evict_data_ram.sv */
`timescale 1ns/1ps

module evict_data_ram #(
    parameter int ADDR_W = evict_pkg::ENTRY_IDX_W,
    parameter int DATA_W = evict_pkg::DATA_WIDTH
) (
    input  logic              clk,
    input  logic              en,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wr_data,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                mem[addr] <= wr_data;
            end else begin
                rd_data <= mem[addr]; // holds until the next read
            end
        end
    end

endmodule

/* evict_group_alloc.sv */
`timescale 1ns/1ps

module evict_group_alloc #(
    parameter int GROUP_NUM = evict_pkg::GROUP_NUM,
    localparam int IDX_W    = (GROUP_NUM > 1) ? $clog2(GROUP_NUM) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             release_vld,
    input  logic [IDX_W-1:0] release_idx,
    output logic             alloc_vld,
    output logic [IDX_W-1:0] alloc_idx,
    input  logic             alloc_rdy
);

    logic [GROUP_NUM-1:0] free_q;
    logic [GROUP_NUM-1:0] free_nxt;
    logic                 take;

    function automatic logic [IDX_W-1:0] lowest_set(input logic [GROUP_NUM-1:0] v);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = GROUP_NUM - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign take = alloc_vld & alloc_rdy;

    always_comb begin
        free_nxt = free_q;
        if (take) begin
            free_nxt[alloc_idx] = 1'b0;
        end
        if (release_vld) begin
            free_nxt[release_idx] = 1'b1;
        end
    end

    // offer is picked from the next vector, so a taken group is never re-offered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_q    <= '1;
            alloc_vld <= 1'b0;
            alloc_idx <= '0;
        end else begin
            free_q    <= free_nxt;
            alloc_vld <= |free_nxt;
            alloc_idx <= lowest_set(free_nxt);
        end
    end

endmodule

/* evict_db.sv */
`timescale 1ns/1ps

module evict_db #(
    parameter int READ_SRAM_DELAY = evict_pkg::DEF_READ_SRAM_DELAY,
    parameter int QUEUE_DEPTH     = evict_pkg::DEF_QUEUE_DEPTH
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              evict_req_vld,
    input  evict_pkg::evict_req_t             evict_req_pld,
    output logic                              evict_req_rdy,
    input  logic [evict_pkg::DATA_WIDTH-1:0]  ram_data,
    input  logic                              ram_data_vld,
    output logic                              evict_clean,
    output logic [evict_pkg::ROB_IDX_W-1:0]   evict_clean_idx,
    output logic                              alloc_vld,
    output logic [evict_pkg::GROUP_IDX_W-1:0] alloc_idx,
    input  logic                              alloc_rdy,
    output logic                              evict_out_vld,
    output evict_pkg::evict_out_t             evict_out_pld,
    input  logic                              evict_out_rdy
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    evict_tap_if tap ();

    logic                                req_fire;
    logic                                wr_go;
    logic                                rd_go;
    logic                                out_fire;
    logic                                ram_en;
    logic [evict_pkg::ENTRY_IDX_W-1:0]   ram_addr;
    logic [evict_pkg::DATA_WIDTH-1:0]    ram_rd_data;
    logic [CNT_W-1:0]                    inflight_cnt;
    logic [CNT_W-1:0]                    q_cnt;
    logic [CNT_W:0]                      occupancy;
    logic [PTR_W-1:0]                    q_wr_ptr;
    logic [PTR_W-1:0]                    q_rd_ptr;
    evict_pkg::evict_req_t               q_mem [QUEUE_DEPTH];
    evict_pkg::evict_req_t               q_head;
    evict_pkg::evict_req_t               out_req;
    logic                                release_vld;

    // in-flight beats plus queued beats never exceed the queue
    assign occupancy     = {1'b0, inflight_cnt} + {1'b0, q_cnt};
    assign evict_req_rdy = occupancy < (CNT_W+1)'(QUEUE_DEPTH);
    assign req_fire      = evict_req_vld & evict_req_rdy;

    evict_delay_line #(
        .READ_SRAM_DELAY (READ_SRAM_DELAY)
    ) u_delay_line (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_fire (req_fire),
        .req_pld  (evict_req_pld),
        .tap      (tap.src)
    );

    assign evict_clean     = tap.clean & ram_data_vld;
    assign evict_clean_idx = tap.clean_rob;

    // write wins the single port
    assign out_fire = evict_out_vld & evict_out_rdy;
    assign wr_go    = tap.wr_vld & ram_data_vld;
    assign q_head   = q_mem[q_rd_ptr];
    assign rd_go    = !wr_go && (q_cnt != '0) && (!evict_out_vld || evict_out_rdy);
    assign ram_en   = wr_go | rd_go;
    assign ram_addr = wr_go ? tap.wr_pld.db_entry_id : q_head.db_entry_id;

    evict_data_ram #(
        .ADDR_W (evict_pkg::ENTRY_IDX_W),
        .DATA_W (evict_pkg::DATA_WIDTH)
    ) u_data_ram (
        .clk     (clk),
        .en      (ram_en),
        .wr_en   (wr_go),
        .addr    (ram_addr),
        .wr_data (ram_data),
        .rd_data (ram_rd_data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight_cnt <= '0;
        end else if (req_fire && !tap.wr_vld) begin
            inflight_cnt <= inflight_cnt + 1'b1;
        end else if (!req_fire && tap.wr_vld) begin
            inflight_cnt <= inflight_cnt - 1'b1;
        end
    end

    // pending queue of written entries
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
        end else begin
            if (wr_go) begin
                q_wr_ptr <= (q_wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
                q_cnt    <= q_cnt + 1'b1;
            end
            if (rd_go) begin
                q_rd_ptr <= (q_rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
                q_cnt    <= q_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            q_mem[q_wr_ptr] <= tap.wr_pld;
        end
        if (rd_go) begin
            out_req <= q_head; // pairs with the ram read register
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            evict_out_vld <= 1'b0;
        end else if (rd_go) begin
            evict_out_vld <= 1'b1;
        end else if (evict_out_rdy) begin
            evict_out_vld <= 1'b0;
        end
    end

    assign evict_out_pld.data         = ram_rd_data;
    assign evict_out_pld.db_entry_id  = out_req.db_entry_id;
    assign evict_out_pld.rob_entry_id = out_req.rob_entry_id;
    assign evict_out_pld.txnid        = out_req.txnid;
    assign evict_out_pld.sideband     = out_req.sideband;
    assign evict_out_pld.addr         = {out_req.tag, out_req.index, out_req.offset};
    assign evict_out_pld.last         = out_req.last;

    assign release_vld = out_fire & out_req.last;

    evict_group_alloc #(
        .GROUP_NUM (evict_pkg::GROUP_NUM)
    ) u_group_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .release_vld (release_vld),
        .release_idx (out_req.db_entry_id[evict_pkg::ENTRY_IDX_W-1 -: evict_pkg::GROUP_IDX_W]),
        .alloc_vld   (alloc_vld),
        .alloc_idx   (alloc_idx),
        .alloc_rdy   (alloc_rdy)
    );

endmodule

/* evict_buffer_top.sv */
`timescale 1ns/1ps

module evict_buffer_top #(
    parameter int READ_SRAM_DELAY = evict_pkg::DEF_READ_SRAM_DELAY,
    parameter int QUEUE_DEPTH     = evict_pkg::DEF_QUEUE_DEPTH
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              evict_req_vld,
    input  evict_pkg::evict_req_t             evict_req_pld,
    output logic                              evict_req_rdy,
    input  logic [evict_pkg::DATA_WIDTH-1:0]  ram_data,
    input  logic                              ram_data_vld,
    output logic                              evict_clean,
    output logic [evict_pkg::ROB_IDX_W-1:0]   evict_clean_idx,
    output logic                              alloc_vld,
    output logic [evict_pkg::GROUP_IDX_W-1:0] alloc_idx,
    input  logic                              alloc_rdy,
    output logic                              evict_out_vld,
    output evict_pkg::evict_out_t             evict_out_pld,
    input  logic                              evict_out_rdy
);

    evict_db #(
        .READ_SRAM_DELAY (READ_SRAM_DELAY),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) u_evict_db (
        .clk             (clk),
        .rst_n           (rst_n),
        .evict_req_vld   (evict_req_vld),
        .evict_req_pld   (evict_req_pld),
        .evict_req_rdy   (evict_req_rdy),
        .ram_data        (ram_data),
        .ram_data_vld    (ram_data_vld),
        .evict_clean     (evict_clean),
        .evict_clean_idx (evict_clean_idx),
        .alloc_vld       (alloc_vld),
        .alloc_idx       (alloc_idx),
        .alloc_rdy       (alloc_rdy),
        .evict_out_vld   (evict_out_vld),
        .evict_out_pld   (evict_out_pld),
        .evict_out_rdy   (evict_out_rdy)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1; // released just after an edge
    end

endmodule

/* evict_asserts.sv */
`timescale 1ns/1ps

module evict_asserts #(
    parameter int READ_SRAM_DELAY = evict_pkg::DEF_READ_SRAM_DELAY,
    parameter int QUEUE_DEPTH     = evict_pkg::DEF_QUEUE_DEPTH
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              evict_req_vld,
    input evict_pkg::evict_req_t             evict_req_pld,
    input logic                              evict_req_rdy,
    input logic [evict_pkg::DATA_WIDTH-1:0]  ram_data,
    input logic                              ram_data_vld,
    input logic                              evict_clean,
    input logic [evict_pkg::ROB_IDX_W-1:0]   evict_clean_idx,
    input logic                              alloc_vld,
    input logic [evict_pkg::GROUP_IDX_W-1:0] alloc_idx,
    input logic                              alloc_rdy,
    input logic                              evict_out_vld,
    input evict_pkg::evict_out_t             evict_out_pld,
    input logic                              evict_out_rdy
);

    localparam int EW = evict_pkg::ENTRY_IDX_W;
    localparam int GW = evict_pkg::GROUP_IDX_W;

    int unsigned err_cnt = 0;

    logic [READ_SRAM_DELAY-1:0]       vld_pipe;
    logic [EW-1:0]                    id_pipe [READ_SRAM_DELAY];
    logic [evict_pkg::DATA_WIDTH-1:0] exp_data [2**EW];
    evict_pkg::evict_req_t            exp_req [2**EW];
    logic [1:0]                       next_beat [evict_pkg::GROUP_NUM];
    logic [evict_pkg::GROUP_NUM-1:0]  busy;     // handed out and last beat not yet accepted
    int                               outstanding; // transferred, not yet accepted downstream
    logic                             req_fire;
    logic                             out_fire;
    logic [GW-1:0]                    out_grp;
    logic [EW-1:0]                    out_id;
    logic [evict_pkg::ROB_IDX_W-1:0]  clean_rob_exp;
    evict_pkg::evict_req_t            out_exp;

    assign req_fire      = evict_req_vld & evict_req_rdy;
    assign out_fire      = evict_out_vld & evict_out_rdy;
    assign out_id        = evict_out_pld.db_entry_id;
    assign out_grp       = out_id[EW-1 -: GW];
    assign out_exp       = exp_req[out_id];
    assign clean_rob_exp = exp_req[id_pipe[READ_SRAM_DELAY-1]].rob_entry_id;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe    <= '0;
            busy        <= '0;
            outstanding <= 0;
            for (int g = 0; g < evict_pkg::GROUP_NUM; g++) begin
                next_beat[g] <= '0;
            end
        end else begin
            vld_pipe[0] <= req_fire;
            for (int i = 1; i < READ_SRAM_DELAY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
            if (req_fire && !out_fire) begin
                outstanding <= outstanding + 1;
            end else if (!req_fire && out_fire) begin
                outstanding <= outstanding - 1;
            end
            if (alloc_vld && alloc_rdy) begin
                busy[alloc_idx] <= 1'b1;
            end
            if (out_fire) begin
                next_beat[out_grp] <= next_beat[out_grp] + 2'd1;
                if (evict_out_pld.last) begin
                    busy[out_grp] <= 1'b0;
                end
            end
        end
    end

    // reference copies of what went into each entry
    always @(posedge clk) begin
        id_pipe[0] <= evict_req_pld.db_entry_id;
        for (int i = 1; i < READ_SRAM_DELAY; i++) begin
            id_pipe[i] <= id_pipe[i-1];
        end
        if (req_fire) begin
            exp_req[evict_req_pld.db_entry_id] <= evict_req_pld;
        end
        if (ram_data_vld && vld_pipe[READ_SRAM_DELAY-1]) begin
            exp_data[id_pipe[READ_SRAM_DELAY-1]] <= ram_data;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !evict_out_vld && !evict_clean && !alloc_vld)
        else begin
            err_cnt = err_cnt + 1;
            $error("outputs not idle while rst_n is low");
        end

    // the beat sitting in the output register no longer counts
    a_req_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        evict_req_rdy == ((outstanding - int'(evict_out_vld)) < QUEUE_DEPTH))
        else begin
            err_cnt = err_cnt + 1;
            $error("mismatch at %0t: evict_req_rdy got %b expected %b", $time,
                   $sampled(evict_req_rdy), !$sampled(evict_req_rdy));
        end

    a_out_data: assert property (@(posedge clk) disable iff (!rst_n)
        evict_out_vld |-> evict_out_pld.data == exp_data[out_id])
        else begin
            err_cnt = err_cnt + 1;
            $error("mismatch at %0t: evict_out_pld.data got %h expected %h", $time,
                   $sampled(evict_out_pld.data), exp_data[$sampled(out_id)]);
        end

    a_out_addr: assert property (@(posedge clk) disable iff (!rst_n)
        evict_out_vld |-> evict_out_pld.addr == {out_exp.tag, out_exp.index, out_exp.offset})
        else begin
            err_cnt = err_cnt + 1;
            $error("mismatch at %0t: evict_out_pld.addr got %h expected %h", $time,
                   $sampled(evict_out_pld.addr),
                   $sampled({out_exp.tag, out_exp.index, out_exp.offset}));
        end

    a_out_fields: assert property (@(posedge clk) disable iff (!rst_n)
        evict_out_vld |-> {evict_out_pld.rob_entry_id, evict_out_pld.txnid,
                           evict_out_pld.sideband, evict_out_pld.last}
                          == {out_exp.rob_entry_id, out_exp.txnid, out_exp.sideband, out_exp.last})
        else begin
            err_cnt = err_cnt + 1;
            $error("mismatch at %0t: evict_out_pld {rob,txnid,sideband,last} got %h expected %h",
                   $time,
                   $sampled({evict_out_pld.rob_entry_id, evict_out_pld.txnid,
                             evict_out_pld.sideband, evict_out_pld.last}),
                   $sampled({out_exp.rob_entry_id, out_exp.txnid, out_exp.sideband,
                             out_exp.last}));
        end

    // beats of a group leave as beat 0, 1, 2, 3
    a_out_order: assert property (@(posedge clk) disable iff (!rst_n)
        evict_out_vld |-> out_id[1:0] == next_beat[out_grp])
        else begin
            err_cnt = err_cnt + 1;
            $error("mismatch at %0t: evict_out_pld.db_entry_id beat got %0d expected %0d", $time,
                   $sampled(out_id[1:0]), $sampled(next_beat[out_grp]));
        end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        evict_out_vld && !evict_out_rdy |=> evict_out_vld && $stable(evict_out_pld))
        else begin
            err_cnt = err_cnt + 1;
            $error("downstream beat changed or vanished while evict_out_rdy was low");
        end

    a_clean_time: assert property (@(posedge clk) disable iff (!rst_n)
        evict_clean == $past(req_fire && evict_req_pld.last, READ_SRAM_DELAY))
        else begin
            err_cnt = err_cnt + 1;
            $error("mismatch at %0t: evict_clean got %b expected %b", $time,
                   $sampled(evict_clean), !$sampled(evict_clean));
        end

    a_clean_idx: assert property (@(posedge clk) disable iff (!rst_n)
        evict_clean |-> evict_clean_idx == clean_rob_exp)
        else begin
            err_cnt = err_cnt + 1;
            $error("mismatch at %0t: evict_clean_idx got %h expected %h", $time,
                   $sampled(evict_clean_idx), $sampled(clean_rob_exp));
        end

    a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_vld |-> !busy[alloc_idx])
        else begin
            err_cnt = err_cnt + 1;
            $error("alloc_idx offers a group whose beats are still outstanding");
        end

    // offer only goes away once every group is out
    a_alloc_drop: assert property (@(posedge clk) disable iff (!rst_n)
        !alloc_vld && $past(alloc_vld) |-> &busy)
        else begin
            err_cnt = err_cnt + 1;
            $error("alloc_vld dropped while a group was still free");
        end

endmodule

bind evict_buffer_top evict_asserts #(
    .READ_SRAM_DELAY (READ_SRAM_DELAY),
    .QUEUE_DEPTH     (QUEUE_DEPTH)
) i_asserts (.*);

/* evict_tb.sv */
`timescale 1ns/1ps

module evict_tb;

    localparam int D            = 3;   // sram read latency
    localparam int QUEUE_DEPTH  = 32;
    localparam int GROUPS       = evict_pkg::GROUP_NUM;
    localparam int EW           = evict_pkg::ENTRY_IDX_W;
    localparam int GW           = evict_pkg::GROUP_IDX_W;
    localparam int TOTAL_GROUPS = 24;
    localparam int MAX_CYCLES   = 40 * TOTAL_GROUPS + 200;

    logic                              clk;
    logic                              rst_n;
    logic                              evict_req_vld;
    evict_pkg::evict_req_t             evict_req_pld;
    logic                              evict_req_rdy;
    logic [evict_pkg::DATA_WIDTH-1:0]  ram_data = '0;
    logic                              ram_data_vld = 1'b0;
    logic                              evict_clean;
    logic [evict_pkg::ROB_IDX_W-1:0]   evict_clean_idx;
    logic                              alloc_vld;
    logic [GW-1:0]                     alloc_idx;
    logic                              alloc_rdy;
    logic                              evict_out_vld;
    evict_pkg::evict_out_t             evict_out_pld;
    logic                              evict_out_rdy = 1'b0;

    int            seed = 30;
    int            cycle_cnt = 0;
    int            groups_done = 0;
    logic [7:0]    use_cnt [GROUPS];
    logic [D-1:0]  pipe_vld = '0;
    logic [EW-1:0] pipe_id [D];
    logic          seen_fire = 1'b0;
    logic [EW-1:0] seen_id = '0;

    tb_clk_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (10)
    ) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    evict_buffer_top #(
        .READ_SRAM_DELAY (D),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) i_dut (.*);

    // id bits land in several fields and the use count marks reuse
    function automatic logic [63:0] beat_pattern(input logic [EW-1:0] id, input logic [7:0] uses);
        return {8'hd0 ^ 8'(id), uses, 16'(id) * 16'h0f1f, (32'(id) * 32'h9e37_79b9) ^ 32'(uses)};
    endfunction

    task automatic take_group(output logic [GW-1:0] grp);
        alloc_rdy = 1'b1;
        @(negedge clk);
        while (!alloc_vld) @(negedge clk);
        grp = alloc_idx;
        @(posedge clk);
        #1;
        alloc_rdy = 1'b0;
        use_cnt[grp] = use_cnt[grp] + 8'd1;
    endtask

    task automatic send_beat(input logic [GW-1:0] grp, input int beat);
        evict_req_pld.db_entry_id  = {grp, 2'(beat)};
        evict_req_pld.rob_entry_id = 4'($random(seed));
        evict_req_pld.txnid        = 8'($random(seed));
        evict_req_pld.sideband     = 4'($random(seed));
        evict_req_pld.tag          = 20'($random(seed));
        evict_req_pld.index        = 6'($random(seed));
        evict_req_pld.offset       = 6'($random(seed));
        evict_req_pld.last         = (beat == 3);
        evict_req_vld = 1'b1;
        @(negedge clk);
        while (!evict_req_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        evict_req_vld = 1'b0;
    endtask

    // sram model returns data D cycles after the request transfer
    always @(posedge clk) begin
        #1;
        for (int i = D - 1; i > 0; i--) begin
            pipe_vld[i] = pipe_vld[i-1];
            pipe_id[i]  = pipe_id[i-1];
        end
        pipe_vld[0]  = seen_fire;
        pipe_id[0]   = seen_id;
        ram_data_vld = pipe_vld[D-1];
        ram_data     = pipe_vld[D-1] ?
                       beat_pattern(pipe_id[D-1], use_cnt[pipe_id[D-1][EW-1 -: GW]]) : '0;
    end

    always @(posedge clk) begin
        #1;
        evict_out_rdy = ($random(seed) % 4) != 0; // stall about one cycle in four
    end

    always @(negedge clk) begin
        seen_fire = evict_req_vld & evict_req_rdy;
        seen_id   = evict_req_pld.db_entry_id;
        cycle_cnt = cycle_cnt + 1;
        if (evict_out_vld && evict_out_rdy && evict_out_pld.last) begin
            groups_done = groups_done + 1;
        end
        if (i_dut.i_asserts.err_cnt != 0) begin
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure in evict_asserts");
        end else if (cycle_cnt >= MAX_CYCLES) begin
            $display("SIMULATION FAILED");
            $fatal(1, "timeout after %0d cycles with %0d groups done", cycle_cnt, groups_done);
        end
    end

    initial begin
        logic [GW-1:0] grp;
        logic [GW-1:0] first_grps [GROUPS];
        evict_req_vld = 1'b0;
        evict_req_pld = '0;
        alloc_rdy     = 1'b0;
        for (int g = 0; g < GROUPS; g++) begin
            use_cnt[g] = '0;
        end
        @(posedge rst_n);
        @(posedge clk);
        #1;
        // empty the free list first so alloc_vld has to drop
        for (int g = 0; g < GROUPS; g++) begin
            take_group(first_grps[g]);
        end
        for (int g = 0; g < GROUPS; g++) begin
            for (int b = 0; b < 4; b++) begin
                send_beat(first_grps[g], b);
            end
        end
        for (int n = GROUPS; n < TOTAL_GROUPS; n++) begin
            take_group(grp);
            for (int b = 0; b < 4; b++) begin
                send_beat(grp, b);
            end
        end
        wait (groups_done == TOTAL_GROUPS);
        repeat (5) @(posedge clk);
        if (i_dut.i_asserts.err_cnt == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

/* project.f */
evict_pkg.sv
evict_tap_if.sv
evict_delay_line.sv
evict_data_ram.sv
evict_group_alloc.sv
evict_db.sv
evict_buffer_top.sv
tb_clk_gen.sv
evict_asserts.sv
evict_tb.sv

/* run.sh */
#!/bin/sh
# build and run the evict buffer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module evict_tb -f project.f -o evict_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past an assertion so the testbench can end the run
./obj_dir/evict_sim +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
